/* design/io_pkg.sv */
`default_nettype none

package io_pkg;

  typedef logic [31:0] io_addr_t;
  typedef logic [31:0] io_data_t;
  typedef logic [3:0]  io_sel_t;     // address bits 31:28
  typedef logic [7:0]  uart_byte_t;
  typedef logic [9:0]  lcd_word_t;   // {deselect, dc, byte}

  localparam io_sel_t SEL_PORT = 4'd0;
  localparam io_sel_t SEL_UART = 4'd1;
  localparam io_sel_t SEL_LCD  = 4'd2;

  // status word bit positions
  localparam int ST_TX_FULL  = 0;
  localparam int ST_RX_EMPTY = 1;
  localparam int ST_LCD_FULL = 2;
  localparam int ST_LCD_DONE = 3;

  typedef enum logic [1:0] {BUS_IDLE, BUS_WAIT_ACK, BUS_READY} bus_state_t;

  typedef enum logic {TX_IDLE, TX_SEND} uart_tx_state_t;

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} uart_rx_state_t;

  typedef enum logic [1:0] {LCD_IDLE, LCD_SHIFT, LCD_GAP} lcd_state_t;

endpackage

`default_nettype wire

/* design/io_bus_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module io_bus_ctrl (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire io_pkg::io_addr_t   io_address,
  input  wire                     io_req,
  input  wire                     io_nwr,
  input  wire io_pkg::io_data_t   io_wdata,
  input  wire                     uart_ack,
  input  wire io_pkg::uart_byte_t uart_rdata,
  input  wire                     uart_tx_full,
  input  wire                     uart_rx_empty,
  input  wire                     lcd_ack,
  input  wire                     lcd_full,
  input  wire                     lcd_done,
  output io_pkg::io_data_t        io_rdata,
  output logic                    io_ready,
  output logic                    led,
  output logic                    uart_req,
  output logic                    lcd_req
);
  import io_pkg::*;

  bus_state_t state;
  io_sel_t    sel;
  logic       uart_sel;
  logic       lcd_wr;
  logic       port_wr;
  logic       settle;   // one decode cycle before a local target completes
  logic       done;
  io_data_t   status_word;

  assign sel      = io_address[31:28];
  assign uart_sel = sel == SEL_UART;
  assign lcd_wr   = sel == SEL_LCD && !io_nwr;   // lcd link is write only
  assign port_wr  = sel == SEL_PORT && !io_nwr;

  // no request raised means the access finishes here
  assign done = !settle && (uart_req ? uart_ack : (lcd_req ? lcd_ack : 1'b1));

  always_comb begin
    status_word = '0;
    status_word[ST_TX_FULL]  = uart_tx_full;
    status_word[ST_RX_EMPTY] = uart_rx_empty;
    status_word[ST_LCD_FULL] = lcd_full;
    status_word[ST_LCD_DONE] = lcd_done;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= BUS_IDLE;
      io_ready <= 1'b0;
      uart_req <= 1'b0;
      lcd_req  <= 1'b0;
      settle   <= 1'b0;
      led      <= 1'b1;
    end else begin
      case (state)
        BUS_IDLE: begin
          if (io_req) begin
            uart_req <= uart_sel;
            lcd_req  <= lcd_wr;
            settle   <= 1'b1;
            state    <= BUS_WAIT_ACK;
          end
        end
        BUS_WAIT_ACK: begin
          settle <= 1'b0;
          if (done) begin
            uart_req <= 1'b0;   // peripheral drops ack in turn
            lcd_req  <= 1'b0;
            io_ready <= 1'b1;
            if (port_wr)
              led <= io_wdata[0];
            state <= BUS_READY;
          end
        end
        BUS_READY: begin
          if (!io_req) begin
            io_ready <= 1'b0;
            state    <= BUS_IDLE;
          end
        end
        default: state <= BUS_IDLE;
      endcase
    end
  end

  // captured together with the rise of io_ready
  always_ff @(posedge clk) begin
    if (state == BUS_WAIT_ACK && done)
      io_rdata <= (uart_sel && io_nwr) ? {24'h0, uart_rdata} : status_word;
  end

endmodule

`default_nettype wire

/* design/uart_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_fifo #(
  parameter int unsigned CLK_DIV   = 868,
  parameter int unsigned FIFO_BITS = 4
) (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     req,
  input  wire                     nwr,
  input  wire io_pkg::uart_byte_t data_in,
  input  wire                     rx,
  output logic                    ack,
  output io_pkg::uart_byte_t      data_out,
  output logic                    tx,
  output logic                    tx_full,
  output logic                    rx_empty
);
  import io_pkg::*;

  localparam int unsigned DEPTH = 1 << FIFO_BITS;
  localparam int unsigned CNT_W = $clog2(CLK_DIV + 1);
  localparam logic [CNT_W-1:0] BIT_END  = CNT_W'(CLK_DIV - 1);
  localparam logic [CNT_W-1:0] STOP_END = CNT_W'(CLK_DIV - 2);
  localparam logic [CNT_W-1:0] HALF_END = CNT_W'(CLK_DIV / 2 - 1);

  uart_byte_t         tx_mem [DEPTH];
  uart_byte_t         rx_mem [DEPTH];
  logic [FIFO_BITS:0] tx_wr, tx_rd, rx_wr, rx_rd;
  logic               tx_empty, rx_full;
  logic               tx_push, tx_pop, rx_push, rx_pop;

  uart_tx_state_t   tx_state;
  logic [8:0]       tx_frame;   // data then stop, start already on the line
  logic [3:0]       tx_bit;
  logic [CNT_W-1:0] tx_cnt;

  uart_rx_state_t   rx_state;
  logic             rx_meta, rx_sync;
  uart_byte_t       rx_shift;
  logic [2:0]       rx_bit;
  logic [CNT_W-1:0] rx_cnt;

  assign tx_empty = tx_wr == tx_rd;
  assign tx_full  = (tx_wr[FIFO_BITS] != tx_rd[FIFO_BITS]) &&
                    (tx_wr[FIFO_BITS-1:0] == tx_rd[FIFO_BITS-1:0]);
  assign rx_empty = rx_wr == rx_rd;
  assign rx_full  = (rx_wr[FIFO_BITS] != rx_rd[FIFO_BITS]) &&
                    (rx_wr[FIFO_BITS-1:0] == rx_rd[FIFO_BITS-1:0]);

  assign tx_push = req && !ack && !nwr && !tx_full;   // full fifo holds off the ack
  assign rx_pop  = req && !ack && nwr && !rx_empty;
  assign tx_pop  = tx_state == TX_IDLE && !tx_empty;
  assign rx_push = rx_state == RX_STOP && rx_cnt == BIT_END && rx_sync && !rx_full;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack   <= 1'b0;
      tx_wr <= '0;
      rx_rd <= '0;
    end else begin
      ack <= req && (ack || tx_push || rx_pop);
      if (tx_push)
        tx_wr <= tx_wr + 1'b1;
      if (rx_pop)
        rx_rd <= rx_rd + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (tx_push)
      tx_mem[tx_wr[FIFO_BITS-1:0]] <= data_in;
    if (rx_push)
      rx_mem[rx_wr[FIFO_BITS-1:0]] <= rx_shift;
    if (rx_pop)
      data_out <= rx_mem[rx_rd[FIFO_BITS-1:0]];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tx_state <= TX_IDLE;
      tx       <= 1'b1;
      tx_rd    <= '0;
      tx_bit   <= '0;
      tx_cnt   <= '0;
    end else if (tx_state == TX_IDLE) begin
      if (tx_pop) begin
        tx_frame <= {1'b1, tx_mem[tx_rd[FIFO_BITS-1:0]]};
        tx       <= 1'b0;   // start bit
        tx_rd    <= tx_rd + 1'b1;
        tx_bit   <= '0;
        tx_cnt   <= '0;
        tx_state <= TX_SEND;
      end
    end else if (tx_bit == 4'd9 && tx_cnt == STOP_END) begin
      tx_state <= TX_IDLE;   // last stop cycle is spent in idle
    end else if (tx_cnt == BIT_END) begin
      tx_cnt   <= '0;
      tx       <= tx_frame[0];
      tx_frame <= {1'b1, tx_frame[8:1]};
      tx_bit   <= tx_bit + 1'b1;
    end else begin
      tx_cnt <= tx_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_meta  <= 1'b1;
      rx_sync  <= 1'b1;
      rx_state <= RX_IDLE;
      rx_wr    <= '0;
      rx_bit   <= '0;
      rx_cnt   <= '0;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_cnt  <= rx_cnt + 1'b1;
      if (rx_push)
        rx_wr <= rx_wr + 1'b1;
      case (rx_state)
        RX_IDLE: begin
          rx_cnt <= '0;
          if (!rx_sync)
            rx_state <= RX_START;
        end
        RX_START: if (rx_cnt == HALF_END) begin
          rx_cnt   <= '0;
          rx_bit   <= '0;
          rx_state <= rx_sync ? RX_IDLE : RX_DATA;   // glitch, not a start bit
        end
        RX_DATA: if (rx_cnt == BIT_END) begin
          rx_cnt   <= '0;
          rx_shift <= {rx_sync, rx_shift[7:1]};   // lsb first
          rx_bit   <= rx_bit + 1'b1;
          if (rx_bit == 3'd7)
            rx_state <= RX_STOP;
        end
        RX_STOP: if (rx_cnt == BIT_END)
          rx_state <= RX_IDLE;
        default: rx_state <= RX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/spi_lcd.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_lcd #(
  parameter int unsigned FIFO_BITS = 4,
  parameter int unsigned CLK_DIV   = 4
) (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    req,
  input  wire io_pkg::lcd_word_t data_in,
  output logic                   ack,
  output logic                   sck,
  output logic                   mosi,
  output logic                   ncs,
  output logic                   dc,
  output logic                   fifo_full,
  output logic                   done
);
  import io_pkg::*;

  localparam int unsigned DEPTH = 1 << FIFO_BITS;
  localparam int unsigned CNT_W = $clog2(CLK_DIV + 1);
  localparam logic [CNT_W-1:0] HALF_END = CNT_W'(CLK_DIV - 1);

  lcd_word_t          mem [DEPTH];
  lcd_word_t          head;
  logic [FIFO_BITS:0] wr_ptr, rd_ptr;
  logic               empty, push, pop, tick;
  lcd_state_t         state;
  logic [7:0]         shreg;
  logic               desel;
  logic [2:0]         bit_cnt;
  logic [CNT_W-1:0]   div_cnt;

  assign head      = mem[rd_ptr[FIFO_BITS-1:0]];
  assign empty     = wr_ptr == rd_ptr;
  assign fifo_full = (wr_ptr[FIFO_BITS] != rd_ptr[FIFO_BITS]) &&
                     (wr_ptr[FIFO_BITS-1:0] == rd_ptr[FIFO_BITS-1:0]);
  assign push      = req && !ack && !fifo_full;
  assign pop       = state == LCD_IDLE && !empty;
  assign tick      = div_cnt == HALF_END;   // half sck period
  assign done      = empty && state == LCD_IDLE;

  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr[FIFO_BITS-1:0]] <= data_in;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack    <= 1'b0;
      wr_ptr <= '0;
    end else begin
      ack <= req && (ack || push);
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= LCD_IDLE;
      sck     <= 1'b0;
      mosi    <= 1'b0;
      ncs     <= 1'b1;
      dc      <= 1'b0;
      rd_ptr  <= '0;
      bit_cnt <= '0;
      div_cnt <= '0;
    end else begin
      div_cnt <= (state == LCD_IDLE || tick) ? '0 : div_cnt + 1'b1;
      case (state)
        LCD_IDLE: if (pop) begin
          shreg   <= head[7:0];
          mosi    <= head[7];   // msb first
          dc      <= head[8];
          desel   <= head[9];
          ncs     <= 1'b0;
          rd_ptr  <= rd_ptr + 1'b1;
          bit_cnt <= '0;
          state   <= LCD_SHIFT;
        end
        LCD_SHIFT: if (tick) begin
          sck <= !sck;
          if (sck) begin
            if (bit_cnt == 3'd7) begin
              state <= LCD_GAP;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
              shreg   <= {shreg[6:0], 1'b0};
              mosi    <= shreg[6];   // changes on falling sck
            end
          end
        end
        LCD_GAP: if (tick) begin
          if (desel)
            ncs <= 1'b1;
          state <= LCD_IDLE;
        end
        default: state <= LCD_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/io_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module io_subsys #(
  parameter int unsigned UART_CLK_DIV   = 868,
  parameter int unsigned UART_FIFO_BITS = 4,
  parameter int unsigned LCD_FIFO_BITS  = 4,
  parameter int unsigned LCD_CLK_DIV    = 4
) (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire io_pkg::io_addr_t io_address,
  input  wire                   io_req,
  input  wire                   io_nwr,
  input  wire io_pkg::io_data_t io_wdata,
  output wire io_pkg::io_data_t io_rdata,
  output wire                   io_ready,
  output wire                   led,
  output wire                   tx,
  input  wire                   rx,
  output wire                   sck,
  output wire                   mosi,
  output wire                   ncs,
  output wire                   dc
);
  import io_pkg::*;

  logic       uart_req, uart_ack, uart_tx_full, uart_rx_empty;
  uart_byte_t uart_rdata;
  logic       lcd_req, lcd_ack, lcd_full, lcd_done;

  io_bus_ctrl ctrl (
    .clk(clk), .rst_n(rst_n), .io_address(io_address), .io_req(io_req),
    .io_nwr(io_nwr), .io_wdata(io_wdata), .uart_ack(uart_ack), .uart_rdata(uart_rdata),
    .uart_tx_full(uart_tx_full), .uart_rx_empty(uart_rx_empty), .lcd_ack(lcd_ack),
    .lcd_full(lcd_full), .lcd_done(lcd_done), .io_rdata(io_rdata), .io_ready(io_ready),
    .led(led), .uart_req(uart_req), .lcd_req(lcd_req)
  );

  uart_fifo #(.CLK_DIV(UART_CLK_DIV), .FIFO_BITS(UART_FIFO_BITS)) ufifo (
    .clk(clk), .rst_n(rst_n), .req(uart_req), .nwr(io_nwr), .data_in(io_wdata[7:0]),
    .rx(rx), .ack(uart_ack), .data_out(uart_rdata), .tx(tx), .tx_full(uart_tx_full),
    .rx_empty(uart_rx_empty)
  );

  spi_lcd #(.FIFO_BITS(LCD_FIFO_BITS), .CLK_DIV(LCD_CLK_DIV)) slcd (
    .clk(clk), .rst_n(rst_n), .req(lcd_req), .data_in(io_wdata[9:0]), .ack(lcd_ack),
    .sck(sck), .mosi(mosi), .ncs(ncs), .dc(dc), .fifo_full(lcd_full), .done(lcd_done)
  );

endmodule

`default_nettype wire

/* bench/io_subsys_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module io_subsys_properties (
  input wire clk,
  input wire rst_n,
  input wire io_req,
  input wire io_ready,
  input wire uart_req,
  input wire lcd_req,
  input wire lcd_ack,
  input wire sck,
  input wire ncs
);

  ready_release: assert property (@(posedge clk) disable iff (!rst_n)
    !io_req && $past(!io_req) |-> !io_ready)
    else $error("io_ready still high after io_req was low for two cycles");

  one_request: assert property (@(posedge clk) disable iff (!rst_n) !(uart_req && lcd_req))
    else $error("uart_req and lcd_req high together");

  sck_idle: assert property (@(posedge clk) disable iff (!rst_n) ncs |-> !sck)
    else $error("sck high while ncs is high");

  // req is still held when the ack arrives
  lcd_handshake: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(lcd_ack) |-> lcd_req)
    else $error("lcd_ack rose without lcd_req");

endmodule

bind io_subsys io_subsys_properties props (
  .clk(clk), .rst_n(rst_n), .io_req(io_req), .io_ready(io_ready), .uart_req(uart_req),
  .lcd_req(lcd_req), .lcd_ack(lcd_ack), .sck(sck), .ncs(ncs)
);

`default_nettype wire

/* bench/io_subsys_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module io_subsys_tb;
  import io_pkg::*;

  localparam int UART_DIV = 8;
  localparam int LCD_DIV  = 2;
  localparam int N_UART   = 6;
  localparam int N_LCD    = 6;
  localparam int N_BURST  = 8;
  localparam int READY_BOUND = 40 * UART_DIV + 100;   // longest stall is about one frame
  localparam int RUN_CYCLES  = 4 * ((N_UART + 2) * 10 * UART_DIV
                               + (N_LCD + N_BURST) * (16 * LCD_DIV + 4)) + 2000;
  localparam io_addr_t ADDR_PORT = {SEL_PORT, 28'h0};
  localparam io_addr_t ADDR_UART = {SEL_UART, 28'h0};
  localparam io_addr_t ADDR_LCD  = {SEL_LCD, 28'h0};
  localparam io_addr_t ADDR_NONE = {4'hf, 28'h0};
  localparam io_data_t IDLE_STATUS = (1 << ST_RX_EMPTY) | (1 << ST_LCD_DONE);

  logic        clk = 1'b0;
  logic        rst_n;
  io_addr_t    io_address;
  logic        io_req;
  logic        io_nwr;
  io_data_t    io_wdata;
  wire io_data_t io_rdata;
  wire         io_ready, led, tx, rx, sck, mosi, ncs, dc;
  logic        loopback;
  logic        rx_drive;
  logic        stop_reached;
  logic [31:0] lfsr = 32'hacb19ad2;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  lcd_word_t   spi_seen[$];
  lcd_word_t   lcd_expected[$];
  logic [7:0]  spi_shift;
  int          spi_bits = 0;

  assign rx = loopback ? tx : rx_drive;

  io_subsys #(
    .UART_CLK_DIV(UART_DIV), .UART_FIFO_BITS(2), .LCD_FIFO_BITS(2), .LCD_CLK_DIV(LCD_DIV)
  ) uut (
    .clk(clk), .rst_n(rst_n), .io_address(io_address), .io_req(io_req), .io_nwr(io_nwr),
    .io_wdata(io_wdata), .io_rdata(io_rdata), .io_ready(io_ready), .led(led), .tx(tx),
    .rx(rx), .sck(sck), .mosi(mosi), .ncs(ncs), .dc(dc)
  );

  always #2 clk = ~clk;

  initial begin
    #(RUN_CYCLES * 4);
    $display("watchdog expired before the tests finished");
    $display("ERRORS FOUND");
    $finish;
  end

  // spi mode 0, msb first
  always @(posedge sck) begin
    spi_shift = {spi_shift[6:0], mosi};
    spi_bits++;
    if (ncs) begin
      $display("sck rose while ncs was high");
      errors++;
    end
    if (spi_bits == 8) begin
      spi_seen.push_back({1'b0, dc, spi_shift});
      spi_bits = 0;
    end
  end

  always @(posedge ncs) begin : ncs_monitor
    lcd_word_t last;
    if (rst_n === 1'b1) begin
      if (spi_bits != 0 || spi_seen.size() == 0 || spi_seen[spi_seen.size() - 1][9]) begin
        $display("ncs rose away from the end of a byte");
        errors++;
      end else begin
        last = spi_seen.pop_back();
        last[9] = 1'b1;   // deselect seen after this byte
        spi_seen.push_back(last);
      end
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    repeat (n) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // starts and ends on a falling edge
  task automatic bus_access(input io_addr_t addr, input logic nwr, input io_data_t wdata,
                            output io_data_t rdata);
    int waited;
    waited = 0;
    io_address = addr;
    io_nwr = nwr;
    io_wdata = wdata;
    io_req = 1'b1;
    @(negedge clk);
    while (!io_ready && waited < READY_BOUND) begin
      @(negedge clk);
      waited++;
    end
    if (!io_ready) begin
      $display("no io_ready within %0d cycles for address %h", READY_BOUND, addr);
      errors++;
    end
    rdata = io_rdata;
    io_req = 1'b0;
    while (io_ready)
      @(negedge clk);
  endtask

  task automatic bus_write(input io_addr_t addr, input io_data_t data);
    io_data_t unused;
    bus_access(addr, 1'b0, data, unused);
  endtask

  task automatic bus_read(input io_addr_t addr, output io_data_t data);
    bus_access(addr, 1'b1, '0, data);
  endtask

  task automatic poll_status(input int bit_pos, input logic level, output logic seen);
    io_data_t st;
    seen = 1'b0;
    for (int i = 0; i < READY_BOUND && !seen; i++) begin
      bus_read(ADDR_PORT, st);
      seen = st[bit_pos] == level;
    end
  endtask

  task automatic serial_send(input uart_byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      stop_reached = i == 9;
      rx_drive = frame[i];
      repeat (UART_DIV) @(negedge clk);
    end
  endtask

  task automatic compare_spi();
    check_value("spi word count", spi_seen.size(), lcd_expected.size());
    foreach (lcd_expected[i])
      if (i < spi_seen.size())
        check_value("spi word {desel,dc,byte}", spi_seen[i], lcd_expected[i]);
    spi_seen.delete();
    lcd_expected.delete();
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests++;
    $display("test %0d %s: %s", tests, name, errors == errors_before ? "ok" : "failed");
  endtask

  task automatic test_reset();
    int e0;
    io_data_t st;
    e0 = errors;
    check_value("led", led, 1);
    check_value("ncs", ncs, 1);
    check_value("tx", tx, 1);
    check_value("sck", sck, 0);
    bus_read(ADDR_PORT, st);
    check_value("status", st, IDLE_STATUS);
    end_test("reset state", e0);
  endtask

  task automatic test_port();
    int e0;
    logic [31:0] v;
    io_data_t st;
    e0 = errors;
    repeat (8) begin
      take_bits(32, v);
      bus_write(ADDR_PORT, v);
      check_value("led", led, v[0]);
    end
    bus_read(ADDR_NONE, st);
    check_value("status at unused selector", st, IDLE_STATUS);
    end_test("led port", e0);
  endtask

  task automatic test_loopback();
    int e0;
    logic [31:0] v;
    io_data_t d;
    logic seen;
    uart_byte_t sent[$];
    e0 = errors;
    loopback = 1'b1;
    repeat (N_UART) begin
      take_bits(8, v);
      sent.push_back(v[7:0]);
      bus_write(ADDR_UART, v);   // stalls while the tx fifo is full
    end
    // one byte on the line and four queued
    bus_read(ADDR_PORT, d);
    check_value("tx full after writes", d[ST_TX_FULL], 1);
    poll_status(ST_RX_EMPTY, 1'b0, seen);
    check_value("rx empty cleared", seen, 1);
    foreach (sent[i]) begin
      bus_read(ADDR_UART, d);
      check_value("uart rdata", d, {24'h0, sent[i]});
    end
    bus_read(ADDR_PORT, d);
    check_value("rx empty after reads", d[ST_RX_EMPTY], 1);
    end_test("uart loopback", e0);
  endtask

  task automatic test_rx_stall();
    int e0;
    logic [31:0] v;
    io_data_t d;
    e0 = errors;
    loopback = 1'b0;
    stop_reached = 1'b0;
    take_bits(8, v);
    fork
      begin
        bus_read(ADDR_UART, d);
        check_value("stop bit reached before io_ready", stop_reached, 1);
      end
      begin
        repeat (4 * UART_DIV) begin
          @(negedge clk);
          check_value("io_ready during stall", io_ready, 0);
        end
        serial_send(v[7:0]);
      end
    join
    check_value("uart rdata", d, {24'h0, v[7:0]});
    end_test("uart read stall", e0);
  endtask

  task automatic test_lcd();
    int e0;
    logic [31:0] v;
    logic desel;
    logic seen;
    lcd_word_t w;
    e0 = errors;
    for (int i = 0; i < N_LCD; i++) begin
      take_bits(8, v);
      desel = i % 3 == 2 || i == N_LCD - 1;
      w = {desel, i[0], v[7:0]};
      lcd_expected.push_back(w);
      bus_write(ADDR_LCD, w);
    end
    poll_status(ST_LCD_DONE, 1'b1, seen);
    check_value("lcd done", seen, 1);
    compare_spi();
    end_test("lcd words", e0);
  endtask

  task automatic test_burst();
    int e0;
    logic [31:0] v;
    logic full_seen;
    logic seen;
    io_data_t st;
    lcd_word_t w;
    e0 = errors;
    full_seen = 1'b0;
    for (int i = 0; i < N_BURST; i++) begin
      take_bits(8, v);
      w = {i[1] & i[0], i[2], v[7:0]};
      lcd_expected.push_back(w);
      bus_write(ADDR_LCD, w);
      bus_read(ADDR_PORT, st);
      full_seen = full_seen | st[ST_LCD_FULL];
    end
    check_value("lcd full seen", full_seen, 1);
    poll_status(ST_LCD_DONE, 1'b1, seen);
    check_value("lcd done", seen, 1);
    compare_spi();
    end_test("lcd burst", e0);
  endtask

  initial begin
    rst_n = 1'b0;
    io_address = '0;
    io_req = 1'b0;
    io_nwr = 1'b1;
    io_wdata = '0;
    loopback = 1'b1;
    rx_drive = 1'b1;
    stop_reached = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    test_reset();
    test_port();
    test_loopback();
    test_rx_stall();
    test_lcd();
    test_burst();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

/* io_subsys.f */
design/io_pkg.sv
design/io_bus_ctrl.sv
design/uart_fifo.sv
design/spi_lcd.sv
design/io_subsys.sv
bench/io_subsys_properties.sv
bench/io_subsys_tb.sv

/* Bender.yml */
package:
  name: io_subsys

sources:
  - files:
      - design/io_pkg.sv
      - design/io_bus_ctrl.sv
      - design/uart_fifo.sv
      - design/spi_lcd.sv
      - design/io_subsys.sv
  - target: test
    files:
      - bench/io_subsys_properties.sv
      - bench/io_subsys_tb.sv
